// File: hw/riscv_isa_pkg.sv
`default_nettype none

package riscv_isa_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;

    typedef enum logic [6:0] {
        op_reg    = 7'b0110011,
        op_imm    = 7'b0010011,
        op_load   = 7'b0000011,
        op_store  = 7'b0100011,
        op_branch = 7'b1100011,
        op_jal    = 7'b1101111
    } opcode_t;

    // funct3 of the supported ALU operations
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    localparam logic [6:0] F7_SUB = 7'b0100000;

    typedef struct packed {
        logic [6:0] funct7;
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        reg_idx_t   rd;
        opcode_t    opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm12;
        reg_idx_t    rs1;
        logic [2:0]  funct3;
        reg_idx_t    rd;
        opcode_t     opcode;
    } i_fmt_t;

    // store, branch and jal immediates come from the r_fmt fields
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
    } instr_u;

    // addi x0, x0, 0
    localparam word_t NOP_INSTR = 32'h0000_0013;

endpackage

`default_nettype wire

// File: hw/pipe_ctrl_pkg.sv
`default_nettype none

package pipe_ctrl_pkg;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_slt
    } alu_op_t;

    typedef enum logic [1:0] {
        res_alu,
        res_mem,
        res_pc4
    } result_src_t;

    // operand source in execute
    typedef enum logic [1:0] {
        fwd_none,
        fwd_wb,
        fwd_mem
    } fwd_sel_t;

endpackage

`default_nettype wire

// File: hw/pipe_if.sv
`timescale 1ns/1ps
`default_nettype none

interface decode_exec_if;
    import riscv_isa_pkg::*;
    import pipe_ctrl_pkg::*;

    logic        reg_write;
    result_src_t result_src;
    logic        mem_write;
    logic        jump;
    logic        branch;
    alu_op_t     alu_op;
    logic        alu_src;
    word_t       rd1;
    word_t       rd2;
    word_t       pc;
    word_t       pc_plus4;
    word_t       imm;
    reg_idx_t    rs1;
    reg_idx_t    rs2;
    reg_idx_t    rd;

    modport src (output reg_write, result_src, mem_write, jump, branch, alu_op, alu_src,
                 output rd1, rd2, pc, pc_plus4, imm, rs1, rs2, rd);
    modport dst (input reg_write, result_src, mem_write, jump, branch, alu_op, alu_src,
                 input rd1, rd2, pc, pc_plus4, imm, rs1, rs2, rd);
endinterface

interface exec_mem_if;
    import riscv_isa_pkg::*;
    import pipe_ctrl_pkg::*;

    logic        reg_write;
    result_src_t result_src;
    logic        mem_write;
    word_t       alu_result;
    word_t       write_data;
    reg_idx_t    rd;
    word_t       pc_plus4;

    modport src (output reg_write, result_src, mem_write, alu_result, write_data, rd, pc_plus4);
    modport dst (input reg_write, result_src, mem_write, alu_result, write_data, rd, pc_plus4);
endinterface

// write-back result, seen by the register file in the same cycle
interface wb_if;
    import riscv_isa_pkg::*;

    logic     reg_write;
    reg_idx_t rd;
    word_t    result;

    modport src (output reg_write, rd, result);
    modport dst (input reg_write, rd, result);
endinterface

`default_nettype wire

// File: hw/instr_fetch.sv
`timescale 1ns/1ps
`default_nettype none

module instr_fetch #(
    parameter riscv_isa_pkg::word_t RESET_PC = '0
) (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 stall_f,
    input  logic                 stall_d,
    input  logic                 flush_d,
    input  logic                 pc_src,
    input  riscv_isa_pkg::word_t pc_target,
    input  riscv_isa_pkg::word_t instr,
    output riscv_isa_pkg::word_t pc,
    output riscv_isa_pkg::word_t fd_instr,
    output riscv_isa_pkg::word_t fd_pc,
    output riscv_isa_pkg::word_t fd_pc_plus4
);
    import riscv_isa_pkg::*;

    word_t pc_plus4_f;
    word_t pc_next;

    assign pc_plus4_f = pc + 32'd4;
    assign pc_next    = pc_src ? pc_target : pc_plus4_f;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc <= RESET_PC;
        end else if (!stall_f) begin
            pc <= pc_next;
        end
    end

    // flush wins over stall
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            fd_instr <= NOP_INSTR;
        end else if (flush_d) begin
            fd_instr <= NOP_INSTR;
        end else if (!stall_d) begin
            fd_instr <= instr;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_d) begin
            fd_pc       <= pc;
            fd_pc_plus4 <= pc_plus4_f;
        end
    end

endmodule

`default_nettype wire

// File: hw/instr_decode.sv
`timescale 1ns/1ps
`default_nettype none

module instr_decode (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    flush_e,
    input  riscv_isa_pkg::word_t    fd_instr,
    input  riscv_isa_pkg::word_t    fd_pc,
    input  riscv_isa_pkg::word_t    fd_pc_plus4,
    wb_if.dst                       wb,
    decode_exec_if.src              de,
    output riscv_isa_pkg::reg_idx_t rs1_d,
    output riscv_isa_pkg::reg_idx_t rs2_d
);
    import riscv_isa_pkg::*;
    import pipe_ctrl_pkg::*;

    instr_u      ir;
    word_t       rf [32];
    word_t       rd1_d;
    word_t       rd2_d;
    word_t       imm_d;
    logic        reg_write_d;
    result_src_t result_src_d;
    logic        mem_write_d;
    logic        jump_d;
    logic        branch_d;
    alu_op_t     alu_op_d;
    alu_op_t     alu_fn;
    logic        alu_src_d;

    assign ir    = fd_instr;
    assign rs1_d = ir.r_fmt.rs1;
    assign rs2_d = ir.r_fmt.rs2;

    // funct3 mapping shared by register and immediate forms
    always_comb begin
        case (ir.r_fmt.funct3)
            F3_SLT:  alu_fn = alu_slt;
            F3_OR:   alu_fn = alu_or;
            F3_AND:  alu_fn = alu_and;
            default: alu_fn = alu_add;
        endcase
    end

    always_comb begin
        reg_write_d  = 1'b0;
        result_src_d = res_alu;
        mem_write_d  = 1'b0;
        jump_d       = 1'b0;
        branch_d     = 1'b0;
        alu_op_d     = alu_add;
        alu_src_d    = 1'b0;
        imm_d        = {{20{ir.i_fmt.imm12[11]}}, ir.i_fmt.imm12};
        case (ir.r_fmt.opcode)
            op_reg: begin
                reg_write_d = 1'b1;
                if (ir.r_fmt.funct3 == F3_ADD_SUB && ir.r_fmt.funct7 == F7_SUB) begin
                    alu_op_d = alu_sub;
                end else begin
                    alu_op_d = alu_fn;
                end
            end
            op_imm: begin
                reg_write_d = 1'b1;
                alu_op_d    = alu_fn;
                alu_src_d   = 1'b1;
            end
            op_load: begin
                reg_write_d  = 1'b1;
                result_src_d = res_mem;
                alu_src_d    = 1'b1;
            end
            op_store: begin
                mem_write_d = 1'b1;
                alu_src_d   = 1'b1;
                imm_d       = {{20{ir.r_fmt.funct7[6]}}, ir.r_fmt.funct7, ir.r_fmt.rd};
            end
            op_branch: begin
                branch_d = 1'b1;
                imm_d    = {{20{ir.r_fmt.funct7[6]}}, ir.r_fmt.rd[0], ir.r_fmt.funct7[5:0],
                            ir.r_fmt.rd[4:1], 1'b0};
            end
            op_jal: begin
                reg_write_d  = 1'b1;
                result_src_d = res_pc4;
                jump_d       = 1'b1;
                imm_d        = {{12{ir.r_fmt.funct7[6]}}, ir.r_fmt.rs1, ir.r_fmt.funct3,
                                ir.r_fmt.rs2[0], ir.r_fmt.funct7[5:0], ir.r_fmt.rs2[4:1], 1'b0};
            end
            default: begin
            end
        endcase
    end

    // x0 is never written
    always_ff @(posedge clk) begin
        if (wb.reg_write && wb.rd != '0) begin
            rf[wb.rd] <= wb.result;
        end
    end

    // read-through of the write-back port
    function automatic word_t rf_read(reg_idx_t idx);
        if (idx == '0) begin
            return '0;
        end
        if (wb.reg_write && wb.rd == idx) begin
            return wb.result;
        end
        return rf[idx];
    endfunction

    always_comb begin
        rd1_d = rf_read(rs1_d);
        rd2_d = rf_read(rs2_d);
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            de.reg_write  <= 1'b0;
            de.result_src <= res_alu;
            de.mem_write  <= 1'b0;
            de.jump       <= 1'b0;
            de.branch     <= 1'b0;
            de.alu_op     <= alu_add;
            de.alu_src    <= 1'b0;
        end else if (flush_e) begin
            de.reg_write  <= 1'b0;
            de.result_src <= res_alu;
            de.mem_write  <= 1'b0;
            de.jump       <= 1'b0;
            de.branch     <= 1'b0;
            de.alu_op     <= alu_add;
            de.alu_src    <= 1'b0;
        end else begin
            de.reg_write  <= reg_write_d;
            de.result_src <= result_src_d;
            de.mem_write  <= mem_write_d;
            de.jump       <= jump_d;
            de.branch     <= branch_d;
            de.alu_op     <= alu_op_d;
            de.alu_src    <= alu_src_d;
        end
    end

    always_ff @(posedge clk) begin
        de.rd1      <= rd1_d;
        de.rd2      <= rd2_d;
        de.pc       <= fd_pc;
        de.pc_plus4 <= fd_pc_plus4;
        de.imm      <= imm_d;
        de.rs1      <= rs1_d;
        de.rs2      <= rs2_d;
        de.rd       <= ir.r_fmt.rd;
    end

    // unsupported opcodes reach execute without side effects
    a_unknown_op_quiet: assert property (@(posedge clk) disable iff (!arst_n)
        !(ir.r_fmt.opcode inside {op_reg, op_imm, op_load, op_store, op_branch, op_jal})
        |=> !de.reg_write && !de.mem_write)
        else $error("unknown opcode produced a register or memory write");

endmodule

`default_nettype wire

// File: hw/exec.sv
`timescale 1ns/1ps
`default_nettype none

module exec (
    input  logic                    clk,
    input  logic                    arst_n,
    input  pipe_ctrl_pkg::fwd_sel_t forward_a,
    input  pipe_ctrl_pkg::fwd_sel_t forward_b,
    decode_exec_if.dst              de,
    wb_if.dst                       wb,
    exec_mem_if.src                 em,
    output logic                    pc_src,
    output riscv_isa_pkg::word_t    pc_target
);
    import riscv_isa_pkg::*;
    import pipe_ctrl_pkg::*;

    word_t src_a;
    word_t src_b;
    word_t write_data_e;
    word_t alu_result_e;

    always_comb begin
        case (forward_a)
            fwd_mem: src_a = em.alu_result;
            fwd_wb:  src_a = wb.result;
            default: src_a = de.rd1;
        endcase
        case (forward_b)
            fwd_mem: write_data_e = em.alu_result;
            fwd_wb:  write_data_e = wb.result;
            default: write_data_e = de.rd2;
        endcase
    end

    assign src_b = de.alu_src ? de.imm : write_data_e;

    always_comb begin
        case (de.alu_op)
            alu_sub: alu_result_e = src_a - src_b;
            alu_and: alu_result_e = src_a & src_b;
            alu_or:  alu_result_e = src_a | src_b;
            alu_slt: alu_result_e = {31'b0, $signed(src_a) < $signed(src_b)};
            default: alu_result_e = src_a + src_b;
        endcase
    end

    // beq compares the forwarded operands
    assign pc_src    = de.jump || (de.branch && src_a == write_data_e);
    assign pc_target = de.pc + de.imm;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            em.reg_write  <= 1'b0;
            em.result_src <= res_alu;
            em.mem_write  <= 1'b0;
        end else begin
            em.reg_write  <= de.reg_write;
            em.result_src <= de.result_src;
            em.mem_write  <= de.mem_write;
        end
    end

    always_ff @(posedge clk) begin
        em.alu_result <= alu_result_e;
        em.write_data <= write_data_e;
        em.rd         <= de.rd;
        em.pc_plus4   <= de.pc_plus4;
    end

    // the slot behind a taken branch or jump is always a bubble
    a_redirect_bubble: assert property (@(posedge clk) disable iff (!arst_n)
        pc_src |=> !pc_src && !de.reg_write && !de.mem_write)
        else $error("instruction in the shadow of a taken branch was executed");

endmodule

`default_nettype wire

// File: hw/memory_writeback.sv
`timescale 1ns/1ps
`default_nettype none

module memory_writeback (
    input  logic                 clk,
    input  logic                 arst_n,
    input  riscv_isa_pkg::word_t read_data,
    exec_mem_if.dst              em,
    wb_if.src                    wb,
    output logic                 data_we,
    output riscv_isa_pkg::word_t data_addr,
    output riscv_isa_pkg::word_t din
);
    import riscv_isa_pkg::*;
    import pipe_ctrl_pkg::*;

    result_src_t result_src_w;
    word_t       alu_result_w;
    word_t       read_data_w;
    word_t       pc_plus4_w;

    assign data_we   = em.mem_write;
    assign data_addr = em.alu_result;
    assign din       = em.write_data;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wb.reg_write <= 1'b0;
            result_src_w <= res_alu;
        end else begin
            wb.reg_write <= em.reg_write;
            result_src_w <= em.result_src;
        end
    end

    always_ff @(posedge clk) begin
        alu_result_w <= em.alu_result;
        read_data_w  <= read_data;
        pc_plus4_w   <= em.pc_plus4;
        wb.rd        <= em.rd;
    end

    always_comb begin
        case (result_src_w)
            res_mem: wb.result = read_data_w;
            res_pc4: wb.result = pc_plus4_w;
            default: wb.result = alu_result_w;
        endcase
    end

    a_we_known: assert property (@(posedge clk) disable iff (!arst_n) !$isunknown(data_we))
        else $error("data_we is unknown");

endmodule

`default_nettype wire

// File: hw/hazard_unit.sv
`timescale 1ns/1ps
`default_nettype none

module hazard_unit (
    input  riscv_isa_pkg::reg_idx_t rs1_d,
    input  riscv_isa_pkg::reg_idx_t rs2_d,
    input  logic                    pc_src,
    decode_exec_if.dst              de,
    exec_mem_if.dst                 em,
    wb_if.dst                       wb,
    output pipe_ctrl_pkg::fwd_sel_t forward_a,
    output pipe_ctrl_pkg::fwd_sel_t forward_b,
    output logic                    stall_f,
    output logic                    stall_d,
    output logic                    flush_d,
    output logic                    flush_e
);
    import riscv_isa_pkg::*;
    import pipe_ctrl_pkg::*;

    logic lw_stall;

    // memory stage is younger, so it wins
    function automatic fwd_sel_t fwd_select(reg_idx_t rs);
        if (em.reg_write && em.rd != '0 && em.rd == rs) begin
            return fwd_mem;
        end
        if (wb.reg_write && wb.rd != '0 && wb.rd == rs) begin
            return fwd_wb;
        end
        return fwd_none;
    endfunction

    always_comb begin
        forward_a = fwd_select(de.rs1);
        forward_b = fwd_select(de.rs2);
    end

    assign lw_stall = de.result_src == res_mem && (de.rd == rs1_d || de.rd == rs2_d);

    assign stall_f = lw_stall;
    assign stall_d = lw_stall;
    assign flush_d = pc_src;
    assign flush_e = lw_stall || pc_src;

    // a load in execute can never redirect, so stall and redirect are exclusive
    a_no_stall_on_redirect: assert final (!(stall_f === 1'b1 && pc_src === 1'b1))
        else $error("load-use stall raised during a redirect");

endmodule

`default_nettype wire

// File: hw/riscv_pipeline.sv
`timescale 1ns/1ps
`default_nettype none

module riscv_pipeline #(
    parameter riscv_isa_pkg::word_t RESET_PC = '0
) (
    input  logic                 clk,
    input  logic                 arst_n,
    input  riscv_isa_pkg::word_t instr,
    input  riscv_isa_pkg::word_t read_data,
    output riscv_isa_pkg::word_t pc,
    output logic                 data_we,
    output riscv_isa_pkg::word_t data_addr,
    output riscv_isa_pkg::word_t din
);
    import riscv_isa_pkg::*;
    import pipe_ctrl_pkg::*;

    word_t    fd_instr;
    word_t    fd_pc;
    word_t    fd_pc_plus4;
    reg_idx_t rs1_d;
    reg_idx_t rs2_d;
    logic     pc_src;
    word_t    pc_target;
    fwd_sel_t forward_a;
    fwd_sel_t forward_b;
    logic     stall_f;
    logic     stall_d;
    logic     flush_d;
    logic     flush_e;

    decode_exec_if de_bus ();
    exec_mem_if    em_bus ();
    wb_if          wb_bus ();

    instr_fetch #(
        .RESET_PC(RESET_PC)
    ) i_instr_fetch (
        .clk         (clk),
        .arst_n      (arst_n),
        .stall_f     (stall_f),
        .stall_d     (stall_d),
        .flush_d     (flush_d),
        .pc_src      (pc_src),
        .pc_target   (pc_target),
        .instr       (instr),
        .pc          (pc),
        .fd_instr    (fd_instr),
        .fd_pc       (fd_pc),
        .fd_pc_plus4 (fd_pc_plus4)
    );

    instr_decode i_instr_decode (
        .clk         (clk),
        .arst_n      (arst_n),
        .flush_e     (flush_e),
        .fd_instr    (fd_instr),
        .fd_pc       (fd_pc),
        .fd_pc_plus4 (fd_pc_plus4),
        .wb          (wb_bus.dst),
        .de          (de_bus.src),
        .rs1_d       (rs1_d),
        .rs2_d       (rs2_d)
    );

    exec i_exec (
        .clk       (clk),
        .arst_n    (arst_n),
        .forward_a (forward_a),
        .forward_b (forward_b),
        .de        (de_bus.dst),
        .wb        (wb_bus.dst),
        .em        (em_bus.src),
        .pc_src    (pc_src),
        .pc_target (pc_target)
    );

    memory_writeback i_memory_writeback (
        .clk       (clk),
        .arst_n    (arst_n),
        .read_data (read_data),
        .em        (em_bus.dst),
        .wb        (wb_bus.src),
        .data_we   (data_we),
        .data_addr (data_addr),
        .din       (din)
    );

    hazard_unit i_hazard_unit (
        .rs1_d     (rs1_d),
        .rs2_d     (rs2_d),
        .pc_src    (pc_src),
        .de        (de_bus.dst),
        .em        (em_bus.dst),
        .wb        (wb_bus.dst),
        .forward_a (forward_a),
        .forward_b (forward_b),
        .stall_f   (stall_f),
        .stall_d   (stall_d),
        .flush_d   (flush_d),
        .flush_e   (flush_e)
    );

endmodule

`default_nettype wire

// File: verif/riscv_pipeline_tb.sv
`timescale 1ns/1ps
`default_nettype none

module riscv_pipeline_tb;
    import riscv_isa_pkg::*;

    localparam word_t RESET_PC      = 32'h0000_0000;
    localparam int    MEM_WORDS     = 256;
    localparam int    BLOCKS        = 10;
    localparam int    STORE_TIMEOUT = 200;
    localparam int    END_TIMEOUT   = 2000;
    localparam int    DRAIN_CYCLES  = 10;

    // base opcodes of RV32I
    localparam logic [6:0] OPC_REG    = 7'b0110011;
    localparam logic [6:0] OPC_IMM    = 7'b0010011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;

    logic     clk;
    logic     arst_n;
    word_t    instr;
    word_t    read_data;
    word_t    pc;
    logic     data_we;
    word_t    data_addr;
    word_t    din;

    word_t    imem [MEM_WORDS];
    word_t    dmem [MEM_WORDS];
    word_t    model_mem [MEM_WORDS];
    word_t    exp_addr [$];
    word_t    exp_data [$];
    int       prog_len;
    int       store_idx;
    reg_idx_t last_rd;
    word_t    end_pc;

    riscv_pipeline #(
        .RESET_PC(RESET_PC)
    ) dut_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .instr     (instr),
        .read_data (read_data),
        .pc        (pc),
        .data_we   (data_we),
        .data_addr (data_addr),
        .din       (din)
    );

    always #4 clk = ~clk;

    assign instr     = imem[pc[9:2]];
    assign read_data = dmem[data_addr[9:2]];

    task automatic report_failure(input string line);
        $display("%s", line);
        $display("TESTBENCH FAILED");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic check_store(input word_t addr, input word_t data);
        if (store_idx >= exp_addr.size()) begin
            report_failure($sformatf("Error at %0t: unexpected store of %h to %h",
                                     $time, data, addr));
        end else if (addr !== exp_addr[store_idx] || data !== exp_data[store_idx]) begin
            report_failure($sformatf("Error at %0t: store %0d wrote %h to %h, expected %h to %h",
                                     $time, store_idx, data, addr,
                                     exp_data[store_idx], exp_addr[store_idx]));
        end else begin
            store_idx++;
        end
    endtask

    task automatic check_mem_word(input int idx, input word_t got, input word_t exp);
        if (got !== exp) begin
            report_failure($sformatf("Error at %0t: data memory word %0d is %h, expected %h",
                                     $time, idx, got, exp));
        end
    endtask

    task automatic check_reset_state(input word_t pc_val, input logic we);
        if (pc_val !== RESET_PC || we !== 1'b0) begin
            report_failure($sformatf("Error at %0t: in reset pc=%h data_we=%b, expected pc=%h",
                                     $time, pc_val, we, RESET_PC));
        end
    endtask

    function automatic word_t enc_r(input logic [6:0] f7, input reg_idx_t rs2,
                                    input reg_idx_t rs1, input logic [2:0] f3,
                                    input reg_idx_t rd);
        return {f7, rs2, rs1, f3, rd, OPC_REG};
    endfunction

    function automatic word_t enc_i(input word_t imm, input reg_idx_t rs1,
                                    input logic [2:0] f3, input reg_idx_t rd,
                                    input logic [6:0] opc);
        return {imm[11:0], rs1, f3, rd, opc};
    endfunction

    function automatic word_t enc_s(input word_t off, input reg_idx_t rs2, input reg_idx_t rs1);
        return {off[11:5], rs2, rs1, 3'b010, off[4:0], OPC_STORE};
    endfunction

    function automatic word_t enc_b(input word_t off, input reg_idx_t rs2, input reg_idx_t rs1);
        return {off[12], off[10:5], rs2, rs1, 3'b000, off[4:1], off[11], OPC_BRANCH};
    endfunction

    function automatic word_t enc_j(input word_t off, input reg_idx_t rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
    endfunction

    // word-aligned address in the lower half of data memory
    function automatic word_t rand_data_offset();
        return word_t'(($urandom % 128) * 4);
    endfunction

    // bias towards the last destination to build dependency chains
    function automatic reg_idx_t pick_src();
        if ($urandom % 2) begin
            return last_rd;
        end
        return reg_idx_t'($urandom % 9);
    endfunction

    task automatic emit(input word_t w);
        if (prog_len >= MEM_WORDS) begin
            report_failure("the generated program does not fit in instruction memory");
        end else begin
            imem[prog_len] = w;
            prog_len++;
        end
    endtask

    task automatic gen_random_op();
        reg_idx_t    rd;
        reg_idx_t    rs1;
        reg_idx_t    rs2;
        reg_idx_t    rd2;
        word_t       imm;
        logic [2:0]  f3;
        logic [6:0]  f7;
        int          pick;
        rd   = reg_idx_t'($urandom % 9);
        rs1  = pick_src();
        rs2  = pick_src();
        imm  = $urandom;
        pick = $urandom % 5;
        f7   = 7'b0;
        case (pick)
            0: f3 = 3'b000;
            1: begin
                f3 = 3'b000;
                f7 = 7'b0100000;
            end
            2: f3 = 3'b111;
            3: f3 = 3'b110;
            default: f3 = 3'b010;
        endcase
        case ($urandom % 6)
            0, 1: begin
                emit(enc_r(f7, rs2, rs1, f3, rd));
                last_rd = rd;
            end
            2: begin
                emit(enc_i(imm, rs1, f3, rd, OPC_IMM));
                last_rd = rd;
            end
            3: begin
                emit(enc_i(rand_data_offset(), 5'd0, 3'b010, rd, OPC_LOAD));
                last_rd = rd;
                // consumer right behind the load
                if ($urandom % 2) begin
                    rd2 = reg_idx_t'(1 + $urandom % 8);
                    emit(enc_r(7'b0, rs2, rd, 3'b000, rd2));
                    last_rd = rd2;
                end
            end
            4: emit(enc_s(rand_data_offset(), rs2, 5'd0));
            default: begin
                emit(enc_i(imm, rs1, 3'b000, 5'd0, OPC_IMM));
                emit(enc_s(rand_data_offset(), 5'd0, 5'd0));
            end
        endcase
    endtask

    task automatic gen_program();
        int       n;
        int       k;
        int       ctrl;
        reg_idx_t rs;
        reg_idx_t link;
        prog_len = 0;
        last_rd  = 5'd1;
        for (int r = 1; r <= 8; r++) begin
            emit(enc_i($urandom, 5'd0, 3'b000, reg_idx_t'(r), OPC_IMM));
        end
        for (int b = 0; b < BLOCKS; b++) begin
            n = 3 + $urandom % 4;
            repeat (n) gen_random_op();
            emit(enc_s(rand_data_offset(), last_rd, 5'd0));
            k = 1 + $urandom % 3;
            // every kind of control transfer shows up several times
            ctrl = b % 3;
            link = reg_idx_t'(1 + $urandom % 8);
            rs   = reg_idx_t'(1 + $urandom % 8);
            case (ctrl)
                0: emit(enc_b(word_t'((k + 1) * 4), rs, rs));
                1: emit(enc_b(word_t'((k + 1) * 4), pick_src(), pick_src()));
                default: emit(enc_j(word_t'((k + 1) * 4), link));
            endcase
            repeat (k) gen_random_op();
            if (ctrl == 2) begin
                emit(enc_s(rand_data_offset(), link, 5'd0));
            end
        end
        end_pc = RESET_PC + word_t'(prog_len * 4);
        emit(enc_j(32'd0, 5'd0));
    endtask

    function automatic word_t model_alu(input logic [2:0] f3, input logic sub,
                                        input word_t a, input word_t b);
        case (f3)
            3'b000: return sub ? a - b : a + b;
            3'b010: return {31'b0, $signed(a) < $signed(b)};
            3'b110: return a | b;
            default: return a & b;
        endcase
    endfunction

    // architectural model, returns the number of stores
    function automatic int run_reference();
        word_t      regs [32];
        word_t      mpc;
        word_t      next_pc;
        word_t      w;
        word_t      a;
        word_t      b;
        word_t      addr;
        word_t      res;
        word_t      imm_i;
        word_t      imm_s;
        word_t      imm_b;
        word_t      imm_j;
        logic       write_rd;
        logic       running;
        int         steps;
        foreach (regs[i]) begin
            regs[i] = '0;
        end
        foreach (model_mem[i]) begin
            model_mem[i] = dmem[i];
        end
        mpc     = RESET_PC;
        steps   = 0;
        running = 1'b1;
        while (running && steps < 4096) begin
            w     = imem[mpc[9:2]];
            imm_i = {{20{w[31]}}, w[31:20]};
            imm_s = {{20{w[31]}}, w[31:25], w[11:7]};
            imm_b = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
            imm_j = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
            a        = regs[w[19:15]];
            b        = regs[w[24:20]];
            write_rd = 1'b0;
            res      = '0;
            next_pc  = mpc + 32'd4;
            case (w[6:0])
                OPC_REG: begin
                    write_rd = 1'b1;
                    res      = model_alu(w[14:12], w[31:25] == 7'b0100000, a, b);
                end
                OPC_IMM: begin
                    write_rd = 1'b1;
                    res      = model_alu(w[14:12], 1'b0, a, imm_i);
                end
                OPC_LOAD: begin
                    write_rd = 1'b1;
                    addr     = a + imm_i;
                    res      = model_mem[addr[9:2]];
                end
                OPC_STORE: begin
                    addr = a + imm_s;
                    model_mem[addr[9:2]] = b;
                    exp_addr.push_back(addr);
                    exp_data.push_back(b);
                end
                OPC_BRANCH: begin
                    if (a == b) begin
                        next_pc = mpc + imm_b;
                    end
                end
                OPC_JAL: begin
                    write_rd = 1'b1;
                    res      = mpc + 32'd4;
                    next_pc  = mpc + imm_j;
                    running  = imm_j != '0;
                end
                default: begin
                end
            endcase
            if (write_rd && w[11:7] != 5'd0) begin
                regs[w[11:7]] = res;
            end
            mpc = next_pc;
            steps++;
        end
        return exp_addr.size();
    endfunction

    // stores are checked and committed mid-cycle while the bus is stable
    always @(negedge clk) begin
        if (arst_n === 1'b1) begin
            if ($isunknown(data_we)) begin
                report_failure("data_we went unknown after reset");
            end else if (data_we) begin
                dmem[data_addr[9:2]] = din;
                check_store(data_addr, din);
            end
        end
    end

    initial begin
        int wait_cycles;
        int last_idx;
        int n_stores;
        void'($urandom(28849));
        clk       = 1'b0;
        arst_n    = 1'b0;
        store_idx = 0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            imem[i] = 32'h0000_0013;
            dmem[i] = (word_t'(i * 4) * 32'h0001_0003) ^ 32'hc3a5_0f1e;
        end
        gen_program();
        n_stores = run_reference();
        $display("program of %0d words, %0d stores expected", prog_len, n_stores);

        repeat (8) begin
            @(negedge clk);
            check_reset_state(pc, data_we);
        end
        arst_n = 1'b1;

        wait_cycles = 0;
        last_idx    = 0;
        while (store_idx < n_stores) begin
            if (wait_cycles > STORE_TIMEOUT) begin
                report_failure($sformatf("timeout: expected store %0d of %0d never appeared",
                                         store_idx, n_stores));
            end else begin
                @(posedge clk);
                if (store_idx != last_idx) begin
                    last_idx    = store_idx;
                    wait_cycles = 0;
                end else begin
                    wait_cycles++;
                end
            end
        end

        wait_cycles = 0;
        @(negedge clk);
        while (pc !== end_pc) begin
            if (wait_cycles > END_TIMEOUT) begin
                report_failure("timeout: the core never reached the final jump-to-self loop");
            end else begin
                @(negedge clk);
                wait_cycles++;
            end
        end

        repeat (DRAIN_CYCLES) @(posedge clk);
        for (int i = 0; i < MEM_WORDS; i++) begin
            check_mem_word(i, dmem[i], model_mem[i]);
        end
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: riscv_pipeline.f
hw/riscv_isa_pkg.sv
hw/pipe_ctrl_pkg.sv
hw/pipe_if.sv
hw/instr_fetch.sv
hw/instr_decode.sv
hw/exec.sv
hw/memory_writeback.sv
hw/hazard_unit.sv
hw/riscv_pipeline.sv
verif/riscv_pipeline_tb.sv
